//--- hw/videoDma_settings.svh
//--------------------
// Build constants of the video frame-buffer DMA
// Included by the package and by every RTL module that sizes from them
//--------------------
`ifndef VIDEO_DMA_SETTINGS_SVH
`define VIDEO_DMA_SETTINGS_SVH

// Pixel and bus data width
`define VDMA_DATA_W 16

// Buffer memory address width
`define VDMA_ADRS_W 10

// Entries in the upstream write FIFO
`define VDMA_FIFO_DEPTH 16

// Ready cycles before the engine yields the bus for one cycle
`define VDMA_BURST_LIMIT 64

// Cycles from an accepted read to its data on the bus
`define VDMA_RD_LATENCY 2

// Memory drops ready for one cycle once per this many cycles
`define VDMA_REFRESH_PERIOD 32

`endif

//--- hw/videoDmaPkg.sv
//--------------------
// Shared types of the frame-buffer DMA
// Referenced as videoDmaPkg::name from the RTL and the testbench
//--------------------
`default_nettype none

`include "videoDma_settings.svh"

package videoDmaPkg;

	// --------------------
	// Data and address
	// --------------------

	// One pixel word, also the bus data word
	typedef logic [`VDMA_DATA_W-1:0] pixelT;

	// One buffer memory address
	typedef logic [`VDMA_ADRS_W-1:0] adrsT;

	// --------------------
	// Encodings
	// --------------------

	// Bus command, qualified by busVd
	typedef enum logic
	{
		busWrite = 1'b0,
		busRead  = 1'b1
	} busCmdE;

	// Which frame region is being written
	// roleWriteA writes region A and reads region B
	typedef enum logic
	{
		roleWriteA = 1'b0,
		roleWriteB = 1'b1
	} bufferRoleE;

endpackage

`default_nettype wire

//--- hw/dmaWriteFifo.sv
//--------------------
// Show-ahead FIFO between the upstream pixel source and the DMA engine
// Head word is valid with vd and is popped by re in the same cycle
//--------------------
`default_nettype none

`include "videoDma_settings.svh"

module dmaWriteFifo #(
	parameter int Depth = `VDMA_FIFO_DEPTH,
	parameter int Width = `VDMA_DATA_W
)(
	input  wire logic               iClk,
	input  wire logic               rst,
	// Upstream push side
	input  wire videoDmaPkg::pixelT wd,
	input  wire logic               we,
	output logic                    full,
	// Engine pop side
	output videoDmaPkg::pixelT      rd,
	output logic                    vd,
	output logic                    empty,
	input  wire logic               re
);

	localparam int PtrW = $clog2(Depth);
	localparam int CntW = $clog2(Depth + 1);

	// Storage, no reset needed on the payload
	logic [Width-1:0] mem [Depth];
	logic [PtrW-1:0]  wrPtr;
	logic [PtrW-1:0]  rdPtr;
	logic [CntW-1:0]  count;
	logic             push;
	logic             pop;

	// Writes into a full FIFO are dropped
	assign push = we && !full;
	assign pop  = re && !empty;

	// Flags straight from the occupancy count
	assign full  = (count == CntW'(Depth));
	assign empty = (count == '0);
	assign vd    = !empty;

	// Show-ahead head word
	assign rd = mem[rdPtr];

	always_ff @(posedge iClk)
	begin
		if (push)
			mem[wrPtr] <= wd;
	end

	// --------------------
	// Pointers and count
	// --------------------
	always_ff @(posedge iClk)
	begin
		if (rst)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			// Wrap explicitly so a non power of two depth works
			if (push)
				wrPtr <= (wrPtr == PtrW'(Depth - 1)) ? '0 : wrPtr + 1'b1;
			if (pop)
				rdPtr <= (rdPtr == PtrW'(Depth - 1)) ? '0 : rdPtr + 1'b1;
			// Simultaneous push and pop keeps the level
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;
		end
	end

	// Engine must only pop a valid head word
	popOnlyWhenValid: assert property (@(posedge iClk) disable iff (rst)
		re |-> !empty)
		else $error("FIFO popped while empty");

	// Dropped upstream write must not change a full FIFO
	fullDropsWrite: assert property (@(posedge iClk) disable iff (rst)
		(we && full && !re) |=> full)
		else $error("FIFO accepted a push while full");

endmodule

`default_nettype wire

//--- hw/videoDmaUnit.sv
//--------------------
// DMA engine moving FIFO pixels into one frame region and reading the other
// Reads win the bus, regions swap when both pointers reach their ends
//--------------------
`default_nettype none

`include "videoDma_settings.svh"

module videoDmaUnit (
	input  wire logic               iClk,
	input  wire logic               rst,
	input  wire logic               dmaEn,
	// Region bounds, ends are last address plus one
	input  wire videoDmaPkg::adrsT  frameAdrsA,
	input  wire videoDmaPkg::adrsT  frameAdrsB,
	input  wire videoDmaPkg::adrsT  frameEndA,
	input  wire videoDmaPkg::adrsT  frameEndB,
	// Write FIFO head
	input  wire videoDmaPkg::pixelT fifoRd,
	input  wire logic               fifoVd,
	output logic                    fifoRe,
	// Downstream side
	input  wire logic               pixelRe,
	output videoDmaPkg::pixelT      pixelOut,
	output logic                    pixelOutVd,
	// Bus master to the buffer memory
	output videoDmaPkg::pixelT      busWd,
	output videoDmaPkg::adrsT       busAdrs,
	output logic                    busVd,
	output videoDmaPkg::busCmdE     busCmd,
	input  wire logic               busRdy,
	input  wire videoDmaPkg::pixelT busRd,
	input  wire logic               busRdVd
);

	localparam int YieldW = $clog2(`VDMA_BURST_LIMIT + 1);

	videoDmaPkg::bufferRoleE role;
	videoDmaPkg::adrsT       wrPtr;
	videoDmaPkg::adrsT       rdPtr;
	videoDmaPkg::adrsT       wrEnd;
	videoDmaPkg::adrsT       rdEnd;
	logic [YieldW-1:0]       yieldCnt;
	logic                    yielding;
	logic                    busFree;
	logic                    doRead;
	logic                    doWrite;
	logic                    doSwap;

	// --------------------
	// Scheduling
	// --------------------

	// Region ends follow the current role
	assign wrEnd = (role == videoDmaPkg::roleWriteA) ? frameEndA : frameEndB;
	assign rdEnd = (role == videoDmaPkg::roleWriteA) ? frameEndB : frameEndA;

	// Bus handed to other masters for one cycle
	assign yielding = (yieldCnt == YieldW'(`VDMA_BURST_LIMIT));
	assign busFree  = dmaEn && busRdy && !yielding;

	// Read first, then write, then swap once both sides are done
	assign doRead  = busFree && pixelRe && (rdPtr != rdEnd);
	assign doWrite = busFree && !doRead && fifoVd && (wrPtr != wrEnd);
	assign doSwap  = busFree && (rdPtr == rdEnd) && (wrPtr == wrEnd);

	// Pop goes with the write decision
	assign fifoRe = doWrite;

	// Counts ready cycles, clears after the yield cycle
	always_ff @(posedge iClk)
	begin
		if (rst || !dmaEn || yielding)
			yieldCnt <= '0;
		else if (busRdy)
			yieldCnt <= yieldCnt + 1'b1;
	end

	// --------------------
	// Pointers and role
	// --------------------
	always_ff @(posedge iClk)
	begin
		if (rst || !dmaEn)
		begin
			// Disabled engine parks on the first frame layout
			role  <= videoDmaPkg::roleWriteA;
			wrPtr <= frameAdrsA;
			rdPtr <= frameAdrsB;
		end
		else if (doSwap)
		begin
			if (role == videoDmaPkg::roleWriteA)
			begin
				role  <= videoDmaPkg::roleWriteB;
				wrPtr <= frameAdrsB;
				rdPtr <= frameAdrsA;
			end
			else
			begin
				role  <= videoDmaPkg::roleWriteA;
				wrPtr <= frameAdrsA;
				rdPtr <= frameAdrsB;
			end
		end
		else
		begin
			if (doRead)
				rdPtr <= rdPtr + 1'b1;
			if (doWrite)
				wrPtr <= wrPtr + 1'b1;
		end
	end

	// --------------------
	// Bus request register
	// --------------------

	// A stalled request stays on the bus until ready returns
	always_ff @(posedge iClk)
	begin
		if (rst)
			busVd <= 1'b0;
		else if (busRdy)
			busVd <= doRead || doWrite;
	end

	// Payload of a new request
	always_ff @(posedge iClk)
	begin
		if (doRead || doWrite)
		begin
			busCmd  <= doRead ? videoDmaPkg::busRead : videoDmaPkg::busWrite;
			busAdrs <= doRead ? rdPtr : wrPtr;
			busWd   <= fifoRd;
		end
	end

	// Returned read data, one cycle to the downstream port
	always_ff @(posedge iClk)
	begin
		if (rst)
			pixelOutVd <= 1'b0;
		else
			pixelOutVd <= busRdVd;
	end

	always_ff @(posedge iClk)
	begin
		if (busRdVd)
			pixelOut <= busRd;
	end

	// Read data only for an accepted read, after the fixed latency
	readReturnTiming: assert property (@(posedge iClk) disable iff (rst)
		busRdVd |-> $past(busVd && busRdy && (busCmd == videoDmaPkg::busRead),
			`VDMA_RD_LATENCY))
		else $error("read data returned without a matching accepted read");

endmodule

`default_nettype wire

//--- hw/frameBufferRam.sv
//--------------------
// Single-port buffer memory behind a RAM controller model
// Fixed read latency and a one-cycle refresh stall on busRdy
//--------------------
`default_nettype none

`include "videoDma_settings.svh"

module frameBufferRam (
	input  wire logic                iClk,
	input  wire logic                rst,
	// Bus slave port
	input  wire videoDmaPkg::pixelT  busWd,
	input  wire videoDmaPkg::adrsT   busAdrs,
	input  wire logic                busVd,
	input  wire videoDmaPkg::busCmdE busCmd,
	output logic                     busRdy,
	output videoDmaPkg::pixelT       busRd,
	output logic                     busRdVd
);

	localparam int Words = 1 << `VDMA_ADRS_W;
	localparam int Lat   = `VDMA_RD_LATENCY;
	localparam int RefW  = $clog2(`VDMA_REFRESH_PERIOD);

	videoDmaPkg::pixelT mem [Words];
	videoDmaPkg::pixelT rdPipe [Lat];
	logic [Lat-1:0]     rdVdPipe;
	logic [RefW-1:0]    refreshCnt;
	logic               accept;

	// Frame contents start black
	initial
	begin
		for (int i = 0; i < Words; i++)
			mem[i] = '0;
	end

	// --------------------
	// Refresh stall
	// --------------------

	// Last count of each period is the refresh cycle
	assign busRdy = (refreshCnt != RefW'(`VDMA_REFRESH_PERIOD - 1));

	always_ff @(posedge iClk)
	begin
		if (rst)
			refreshCnt <= '0;
		else if (refreshCnt == RefW'(`VDMA_REFRESH_PERIOD - 1))
			refreshCnt <= '0;
		else
			refreshCnt <= refreshCnt + 1'b1;
	end

	// Transfer needs valid and ready together
	assign accept = busVd && busRdy;

	always @(posedge iClk)
	begin
		if (accept && (busCmd == videoDmaPkg::busWrite))
			mem[busAdrs] <= busWd;
	end

	// --------------------
	// Read delay line
	// --------------------
	always_ff @(posedge iClk)
	begin
		rdPipe[0] <= mem[busAdrs];
		for (int i = 1; i < Lat; i++)
			rdPipe[i] <= rdPipe[i-1];
	end

	// Valid bits, several reads may be in flight
	always_ff @(posedge iClk)
	begin
		if (rst)
			rdVdPipe <= '0;
		else
		begin
			rdVdPipe[0] <= accept && (busCmd == videoDmaPkg::busRead);
			for (int i = 1; i < Lat; i++)
				rdVdPipe[i] <= rdVdPipe[i-1];
		end
	end

	assign busRd   = rdPipe[Lat-1];
	assign busRdVd = rdVdPipe[Lat-1];

	// No access while not ready, the request waits unchanged
	holdWhileStalled: assert property (@(posedge iClk) disable iff (rst)
		(busVd && !busRdy) |=> (busVd && $stable(busAdrs) && $stable(busCmd)))
		else $error("request dropped or changed during refresh stall");

endmodule

`default_nettype wire

//--- hw/videoDmaTop.sv
//--------------------
// Frame-buffer DMA top with write FIFO, engine and buffer memory
// Upstream pushes pixels, downstream pulls the other frame region
//--------------------
`default_nettype none

`include "videoDma_settings.svh"

module videoDmaTop (
	input  wire logic               iClk,
	input  wire logic               rst,
	// Upstream pixel stream
	input  wire videoDmaPkg::pixelT pixelIn,
	input  wire logic               pixelWe,
	output logic                    fifoFull,
	// Downstream pixel stream
	input  wire logic               pixelRe,
	output videoDmaPkg::pixelT      pixelOut,
	output logic                    pixelOutVd,
	// Frame layout and enable
	input  wire videoDmaPkg::adrsT  frameAdrsA,
	input  wire videoDmaPkg::adrsT  frameAdrsB,
	input  wire videoDmaPkg::adrsT  frameEndA,
	input  wire videoDmaPkg::adrsT  frameEndB,
	input  wire logic               dmaEn
);

	// FIFO to engine
	videoDmaPkg::pixelT  fifoRd;
	logic                fifoVd;
	logic                fifoRe;

	// Engine to memory
	videoDmaPkg::pixelT  busWd;
	videoDmaPkg::adrsT   busAdrs;
	logic                busVd;
	videoDmaPkg::busCmdE busCmd;
	logic                busRdy;
	videoDmaPkg::pixelT  busRd;
	logic                busRdVd;

	dmaWriteFifo #(
		.Depth (`VDMA_FIFO_DEPTH),
		.Width (`VDMA_DATA_W)
	) dmaWriteFifo_i (
		.iClk  (iClk),
		.rst   (rst),
		.wd    (pixelIn),
		.we    (pixelWe),
		.full  (fifoFull),
		.rd    (fifoRd),
		.vd    (fifoVd),
		.empty (),
		.re    (fifoRe)
	);

	videoDmaUnit videoDmaUnit_i (
		.iClk       (iClk),
		.rst        (rst),
		.dmaEn      (dmaEn),
		.frameAdrsA (frameAdrsA),
		.frameAdrsB (frameAdrsB),
		.frameEndA  (frameEndA),
		.frameEndB  (frameEndB),
		.fifoRd     (fifoRd),
		.fifoVd     (fifoVd),
		.fifoRe     (fifoRe),
		.pixelRe    (pixelRe),
		.pixelOut   (pixelOut),
		.pixelOutVd (pixelOutVd),
		.busWd      (busWd),
		.busAdrs    (busAdrs),
		.busVd      (busVd),
		.busCmd     (busCmd),
		.busRdy     (busRdy),
		.busRd      (busRd),
		.busRdVd    (busRdVd)
	);

	// Controller model with refresh stalls
	frameBufferRam frameBufferRam_i (
		.iClk    (iClk),
		.rst     (rst),
		.busWd   (busWd),
		.busAdrs (busAdrs),
		.busVd   (busVd),
		.busCmd  (busCmd),
		.busRdy  (busRdy),
		.busRd   (busRd),
		.busRdVd (busRdVd)
	);

endmodule

`default_nettype wire

//--- bench/videoDmaTb.sv
//--------------------
// Testbench for the frame-buffer DMA, driven by the trace file in bench
// Pixels are checked in order as pixelOutVd pulses arrive
//--------------------
`default_nettype none

module videoDmaTb;
	timeunit 1ns;
	timeprecision 100ps;

	// Trace operation codes
	localparam int OpConfig  = 0;
	localparam int OpEnable  = 1;
	localparam int OpDisable = 2;
	localparam int OpPush    = 3;
	localparam int OpRequest = 4;
	localparam int OpExpect  = 5;
	localparam int OpFull    = 6;
	localparam int OpIdle    = 7;
	localparam int OpHold    = 8;
	localparam int OpStream  = 9;

	logic               iClk;
	logic               rst;
	videoDmaPkg::pixelT pixelIn;
	logic               pixelWe;
	logic               fifoFull;
	logic               pixelRe;
	videoDmaPkg::pixelT pixelOut;
	logic               pixelOutVd;
	videoDmaPkg::adrsT  frameAdrsA;
	videoDmaPkg::adrsT  frameAdrsB;
	videoDmaPkg::adrsT  frameEndA;
	videoDmaPkg::adrsT  frameEndB;
	logic               dmaEn;

	// Parsed trace, one entry per operation
	int                 opQ[$];
	int                 argAQ[$];
	int                 argBQ[$];
	int                 argCQ[$];
	int                 argDQ[$];
	videoDmaPkg::pixelT expQ[$];
	int                 outCount;
	int                 limitCycles;

	videoDmaTop videoDmaTop_i (
		.iClk       (iClk),
		.rst        (rst),
		.pixelIn    (pixelIn),
		.pixelWe    (pixelWe),
		.fifoFull   (fifoFull),
		.pixelRe    (pixelRe),
		.pixelOut   (pixelOut),
		.pixelOutVd (pixelOutVd),
		.frameAdrsA (frameAdrsA),
		.frameAdrsB (frameAdrsB),
		.frameEndA  (frameEndA),
		.frameEndB  (frameEndB),
		.dmaEn      (dmaEn)
	);

	initial
	begin
		iClk = 1'b0;
		forever #5 iClk = ~iClk;
	end

	// --------------------
	// Checks
	// --------------------
	task automatic failRun(input string why);
		$display("%s", why);
		$display("STATUS: FAIL");
		$fatal(1);
	endtask

	task automatic checkPixel(input videoDmaPkg::pixelT expected);
		if (pixelOut !== expected)
			failRun($sformatf("MISMATCH at %0t: pixelOut %h, expected %h",
				$time, pixelOut, expected));
	endtask

	task automatic checkFlag(input logic got, input logic expected, input string what);
		if (got !== expected)
			failRun($sformatf("MISMATCH at %0t: %s is %b, expected %b",
				$time, what, got, expected));
	endtask

	// Every returned pixel must have been expected
	always @(negedge iClk)
	begin
		if (!rst && pixelOutVd)
		begin
			if (expQ.size() == 0)
				failRun($sformatf("Unexpected pixel %h returned at %0t", pixelOut, $time));
			else
				checkPixel(expQ.pop_front());
			outCount++;
		end
	end

	// --------------------
	// Stimulus
	// --------------------
	task automatic pushPixels(input int base, input int count, input int step);
		for (int i = 0; i < count; i++)
		begin
			@(negedge iClk);
			pixelIn = videoDmaPkg::pixelT'(base + i * step);
			pixelWe = 1'b1;
		end
		@(negedge iClk);
		pixelWe = 1'b0;
	endtask

	// One-cycle pulse per read, retried when the engine did not take it
	task automatic requestReads(input int count);
		int target;
		for (int i = 0; i < count; i++)
		begin
			target = outCount + 1;
			while (outCount < target)
			begin
				@(negedge iClk);
				pixelRe = 1'b1;
				@(negedge iClk);
				pixelRe = 1'b0;
				repeat (6) @(negedge iClk);
			end
		end
	endtask

	task automatic holdReadRequest(input int cycles);
		@(negedge iClk);
		pixelRe = 1'b1;
		repeat (cycles) @(negedge iClk);
		pixelRe = 1'b0;
	endtask

	task automatic loadTrace();
		int                fd;
		int                n;
		int                a;
		int                b;
		int                c;
		int                d;
		int                op;
		logic [8*128-1:0]  lineText;
		logic [8*16-1:0]   opText;
		fd = $fopen("bench/videoDmaTrace.txt", "r");
		if (fd == 0)
			failRun("Could not open the trace file bench/videoDmaTrace.txt");
		while (!$feof(fd))
		begin
			lineText = '0;
			n = $fgets(lineText, fd);
			opText = '0;
			a = 0;
			b = 0;
			c = 0;
			d = 0;
			if (n > 0 && $sscanf(lineText, "%s", opText) == 1 && opText != "#")
			begin
				op = -1;
				if (opText == "config")
				begin
					op = OpConfig;
					n = $sscanf(lineText, "%s %h %h %h %h", opText, a, b, c, d);
				end
				else if (opText == "enable")
					op = OpEnable;
				else if (opText == "disable")
					op = OpDisable;
				else if (opText == "push" || opText == "expect")
				begin
					op = (opText == "push") ? OpPush : OpExpect;
					n = $sscanf(lineText, "%s %h %d %d", opText, a, b, c);
				end
				else if (opText == "stream")
				begin
					op = OpStream;
					n = $sscanf(lineText, "%s %h %d", opText, a, b);
				end
				else if (opText == "full")
				begin
					op = OpFull;
					n = $sscanf(lineText, "%s %d", opText, a);
				end
				else if (opText == "request" || opText == "idle" || opText == "hold")
				begin
					op = (opText == "request") ? OpRequest :
						(opText == "idle") ? OpIdle : OpHold;
					n = $sscanf(lineText, "%s %d", opText, a);
				end
				if (op < 0)
					failRun($sformatf("Unknown trace operation %0s", opText));
				opQ.push_back(op);
				argAQ.push_back(a);
				argBQ.push_back(b);
				argCQ.push_back(c);
				argDQ.push_back(d);
			end
		end
		$fclose(fd);
	endtask

	// Budget from the trace length, reads may need several tries
	initial
	begin
		wait (limitCycles != 0);
		repeat (limitCycles) @(posedge iClk);
		failRun($sformatf("Timeout: trace did not finish within %0d cycles", limitCycles));
	end

	initial
	begin
		int budget;
		rst = 1'b1;
		pixelIn = '0;
		pixelWe = 1'b0;
		pixelRe = 1'b0;
		frameAdrsA = '0;
		frameAdrsB = '0;
		frameEndA = '0;
		frameEndB = '0;
		dmaEn = 1'b0;
		outCount = 0;
		limitCycles = 0;
		loadTrace();
		budget = 100;
		foreach (opQ[i])
		begin
			budget += 40;
			if (opQ[i] == OpRequest || opQ[i] == OpStream)
				budget += 20 * ((opQ[i] == OpStream) ? argBQ[i] : argAQ[i]);
			else if (opQ[i] == OpIdle || opQ[i] == OpHold)
				budget += argAQ[i];
		end
		// Watchdog starts once the whole budget is known
		limitCycles = budget;
		repeat (5) @(posedge iClk);
		@(negedge iClk);
		rst = 1'b0;

		// --------------------
		// Trace replay
		// --------------------
		foreach (opQ[i])
		begin
			case (opQ[i])
				OpConfig:
				begin
					@(negedge iClk);
					frameAdrsA = videoDmaPkg::adrsT'(argAQ[i]);
					frameAdrsB = videoDmaPkg::adrsT'(argBQ[i]);
					frameEndA  = videoDmaPkg::adrsT'(argCQ[i]);
					frameEndB  = videoDmaPkg::adrsT'(argDQ[i]);
				end
				OpEnable:
				begin
					@(negedge iClk);
					dmaEn = 1'b1;
				end
				OpDisable:
				begin
					@(negedge iClk);
					dmaEn = 1'b0;
				end
				OpPush:
					pushPixels(argAQ[i], argBQ[i], argCQ[i]);
				OpExpect:
				begin
					for (int k = 0; k < argBQ[i]; k++)
						expQ.push_back(videoDmaPkg::pixelT'(argAQ[i] + k * argCQ[i]));
				end
				OpRequest:
					requestReads(argAQ[i]);
				OpFull:
					checkFlag(fifoFull, argAQ[i] != 0, "fifoFull");
				OpIdle:
					repeat (argAQ[i]) @(negedge iClk);
				OpHold:
					holdReadRequest(argAQ[i]);
				default:
				begin
					// Writes and reads side by side
					fork
						pushPixels(argAQ[i], argBQ[i], 1);
						requestReads(argBQ[i]);
					join
				end
			endcase
		end

		if (expQ.size() == 0)
		begin
			$display("STATUS: PASS");
			$finish;
		end
		else
			failRun($sformatf("Run ended with %0d expected pixels never returned", expQ.size()));
	end

endmodule

`default_nettype wire

//--- bench/videoDmaTrace.txt
# Operations: config adrsA adrsB endA endB (hex), enable, disable, full level,
# push/expect base(hex) count step, request n, idle n, hold n, stream base(hex) n
config 000 100 010 110
full 0
# Disabled engine ignores read requests
hold 10
idle 8
full 0
# Fill the FIFO while disabled, extra pushes are dropped
push 0100 16 1
full 1
push 0EEE 2 1
full 1
# First frame reads black region B
enable
expect 0000 16 0
request 16
idle 4
full 0
# Region A now holds the first frame
push 0200 16 1
expect 0100 16 1
request 16
push 0300 16 1
expect 0200 16 1
request 16
# Reads and writes side by side over stalls and yields
expect 0300 16 1
stream 0400 16
expect 0400 16 1
stream 0500 16
idle 4
# Re-enable starts again on region A
disable
idle 2
enable
push 0700 16 1
expect 0400 16 1
request 16
push 0800 16 1
expect 0700 16 1
request 16
idle 10
full 0

//--- videoDmaTop.f
+incdir+hw
hw/videoDmaPkg.sv
hw/dmaWriteFifo.sv
hw/videoDmaUnit.sv
hw/frameBufferRam.sv
hw/videoDmaTop.sv
bench/videoDmaTb.sv

//--- run.sh
#!/bin/sh
# Build and run the frame-buffer DMA testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f videoDmaTop.f --top-module videoDmaTb \
	-o videoDmaSim > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/videoDmaSim > sim.log 2>&1 || echo "simulation returned an error"
cat sim.log
grep -qx "STATUS: PASS" sim.log && echo "run passed" && exit 0 || { echo "run failed"; exit 1; }
